// File: filelist.f
+incdir+include
verilog/l2_mem_pkg.sv
verilog/l2_mem_req_if.sv
verilog/axil_to_mem.sv
verilog/sram_cut.sv
verilog/row_rdata_sel.sv
verilog/l2_mem.sv
bench/tb_l2_mem.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_l2_mem
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/tb_l2_mem.sv
// ##############################
// L2 memory testbench
// Table-driven AXI4-Lite traffic
// checked against a byte model
// ##############################

`timescale 1ns/1ps

`include "l2_mem_consts.svh"

module tb_l2_mem;

  typedef struct {
    bit          is_wr;
    logic [31:0] addr;
    logic [63:0] wdata;
    logic [7:0]  strb;
    int          bdly;
    int          rdly;
    logic [1:0]  exp_resp;
    logic [63:0] exp_data;
  } entry_t;

  logic        clk_i = 1'b0;
  logic        rst_ni;
  logic [31:0] s_awaddr_i;
  logic        s_awvalid_i;
  logic        s_awready_o;
  logic [63:0] s_wdata_i;
  logic [7:0]  s_wstrb_i;
  logic        s_wvalid_i;
  logic        s_wready_o;
  logic [1:0]  s_bresp_o;
  logic        s_bvalid_o;
  logic        s_bready_i;
  logic [31:0] s_araddr_i;
  logic        s_arvalid_i;
  logic        s_arready_o;
  logic [63:0] s_rdata_o;
  logic [1:0]  s_rresp_o;
  logic        s_rvalid_o;
  logic        s_rready_i;

  entry_t      tbl [$];
  logic [31:0] rnd_addr [$];
  logic [7:0]  ref_mem [`L2_N_BYTES];
  logic [31:0] lcg_state   = 32'hcba6bf9a;
  int          errors      = 0;
  int          test_err    = 0;
  int          bad_tests   = 0;
  int          cycles      = 0;
  int          cycle_limit = 0;

  l2_mem i_l2_mem (.*);

  always #10 clk_i = ~clk_i;

  // Limit scales with the table at 16 cycles per entry plus reset
  always @(posedge clk_i) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timed out after %0d cycles, the DUT stopped answering", cycles);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Two words per row near the first and last word of each row
  function automatic logic [31:0] base_addr(input int i);
    return 32'((i / 2) * 2048 + ((i % 2 == 1) ? 2040 : i * 24));
  endfunction

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got %h, expected %h", name, got, exp);
      errors++;
      test_err++;
    end
  endtask

  // Expected values follow the table's own writes through the byte model
  task automatic add_entry(input bit is_wr, input logic [31:0] addr, input logic [7:0] strb,
                           input int bdly, input int rdly);
    entry_t e;
    e = '{is_wr, addr, 64'h0, strb, bdly, rdly, 2'b00, 64'h0};
    if (is_wr) begin
      lcg_state = lcg_next(lcg_state);
      e.wdata[31:0] = lcg_state;
      lcg_state = lcg_next(lcg_state);
      e.wdata[63:32] = lcg_state;
    end
    e.exp_resp = (addr < `L2_N_BYTES) ? 2'b00 : 2'b10;
    if (addr < `L2_N_BYTES) begin
      for (int b = 0; b < 8; b++) begin
        if (is_wr && strb[b]) begin
          ref_mem[addr[12:0] + 13'(b)] = e.wdata[b*8 +: 8];
        end
        e.exp_data[b*8 +: 8] = ref_mem[addr[12:0] + 13'(b)];
      end
    end
    tbl.push_back(e);
  endtask

  task automatic build_table();
    for (int i = 0; i < 8; i++) begin
      add_entry(1'b1, base_addr(i), 8'hFF, i % 3, 0);
    end
    for (int i = 0; i < 8; i++) begin
      add_entry(1'b0, base_addr(i), 8'h00, 0, i % 4);
    end
    // Partial strobes over full words
    add_entry(1'b1, base_addr(1), 8'h0F, 0, 0);
    add_entry(1'b1, base_addr(2), 8'hA5, 1, 0);
    add_entry(1'b1, base_addr(5), 8'h80, 0, 0);
    add_entry(1'b0, base_addr(1), 8'h00, 0, 0);
    add_entry(1'b0, base_addr(2), 8'h00, 0, 2);
    add_entry(1'b0, base_addr(5), 8'h00, 0, 0);
    // Out of range writes would alias words 0 and 8184 if decoded
    add_entry(1'b1, 32'h0000_2000, 8'hFF, 0, 0);
    add_entry(1'b1, 32'hFFFF_FFF8, 8'hFF, 2, 0);
    add_entry(1'b0, 32'h0000_2000, 8'h00, 0, 1);
    add_entry(1'b0, 32'h0001_2008, 8'h00, 0, 0);
    add_entry(1'b0, base_addr(0), 8'h00, 0, 0);
    add_entry(1'b0, base_addr(7), 8'h00, 0, 0);
    // Random words under long back-pressure
    for (int i = 0; i < 4; i++) begin
      lcg_state = lcg_next(lcg_state);
      rnd_addr.push_back(lcg_state & 32'h0000_1FF8);
      add_entry(1'b1, rnd_addr[i], 8'hFF, 3 + i, 0);
    end
    for (int i = 0; i < 4; i++) begin
      add_entry(1'b0, rnd_addr[i], 8'h00, 0, 3 + i);
    end
    add_entry(1'b1, rnd_addr[0], 8'h3C, 0, 0);
    add_entry(1'b1, rnd_addr[3], 8'hC1, 1, 0);
    add_entry(1'b0, rnd_addr[0], 8'h00, 0, 0);
    add_entry(1'b0, rnd_addr[3], 8'h00, 0, 1);
  endtask

  // While waiting, ready stays low and the other channel offers a request
  task automatic hold_state(input bit is_wr, input bit waiting);
    if (is_wr) begin
      s_bready_i  = !waiting;
      s_araddr_i  = 32'h0;
      s_arvalid_i = waiting;
    end else begin
      s_rready_i  = !waiting;
      s_awaddr_i  = 32'hFFFF_0000;
      s_wstrb_i   = 8'h00;
      s_awvalid_i = waiting;
      s_wvalid_i  = waiting;
    end
  endtask

  task automatic take_response(input entry_t e);
    int          dly;
    logic [1:0]  resp_q;
    logic [63:0] data_q;
    string       vname;
    string       rname;
    dly   = e.is_wr ? e.bdly : e.rdly;
    vname = e.is_wr ? "s_bvalid_o" : "s_rvalid_o";
    rname = e.is_wr ? "s_bresp_o" : "s_rresp_o";
    for (int k = 0; k <= dly; k++) begin
      if (k > 0) begin
        @(posedge clk_i);
        #2;
      end
      hold_state(e.is_wr, k < dly);
      @(negedge clk_i);
      if (k == 0) begin
        resp_q = e.is_wr ? s_bresp_o : s_rresp_o;
        data_q = e.is_wr ? 64'h0 : s_rdata_o;
      end else begin
        check_val(rname, 64'(e.is_wr ? s_bresp_o : s_rresp_o), 64'(resp_q));
        if (!e.is_wr) begin
          check_val("s_rdata_o", s_rdata_o, data_q);
        end
      end
      check_val(vname, 64'(e.is_wr ? s_bvalid_o : s_rvalid_o), 64'h1);
      check_val(e.is_wr ? "s_arready_o" : "s_awready_o|s_wready_o",
                64'(e.is_wr ? s_arready_o : (s_awready_o | s_wready_o)), 64'h0);
    end
    @(posedge clk_i);
    #2;
    s_bready_i = 1'b0;
    s_rready_i = 1'b0;
    @(negedge clk_i);
    check_val(vname, 64'(e.is_wr ? s_bvalid_o : s_rvalid_o), 64'h0);
    check_val(rname, 64'(resp_q), 64'(e.exp_resp));
    if (!e.is_wr) begin
      check_val("s_rdata_o", data_q, e.exp_data);
    end
  endtask

  task automatic run_entry(input entry_t e);
    @(posedge clk_i);
    #2;
    if (e.is_wr) begin
      s_awaddr_i  = e.addr;
      s_wdata_i   = e.wdata;
      s_wstrb_i   = e.strb;
      s_awvalid_i = 1'b1;
      s_wvalid_i  = 1'b1;
    end else begin
      s_araddr_i  = e.addr;
      s_arvalid_i = 1'b1;
    end
    @(negedge clk_i);
    while (e.is_wr ? !(s_awready_o && s_wready_o) : !s_arready_o) begin
      @(negedge clk_i);
    end
    // Accepted on the coming edge with bvalid one cycle later and rvalid two
    check_val(e.is_wr ? "s_bvalid_o" : "s_rvalid_o",
              64'(e.is_wr ? s_bvalid_o : s_rvalid_o), 64'h0);
    @(posedge clk_i);
    #2;
    s_awvalid_i = 1'b0;
    s_wvalid_i  = 1'b0;
    s_arvalid_i = 1'b0;
    if (!e.is_wr) begin
      @(negedge clk_i);
      check_val("s_rvalid_o", 64'(s_rvalid_o), 64'h0);
      @(posedge clk_i);
      #2;
    end
    take_response(e);
  endtask

  initial begin
    rst_ni      = 1'b0;
    s_awaddr_i  = '0;
    s_awvalid_i = 1'b0;
    s_wdata_i   = '0;
    s_wstrb_i   = '0;
    s_wvalid_i  = 1'b0;
    s_bready_i  = 1'b0;
    s_araddr_i  = '0;
    s_arvalid_i = 1'b0;
    s_rready_i  = 1'b0;
    for (int a = 0; a < `L2_N_BYTES; a++) begin
      ref_mem[13'(a)] = 8'h00;
    end
    build_table();
    cycle_limit = tbl.size() * 16 + 20;
    repeat (8) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_val("s_awready_o", 64'(s_awready_o), 64'h0);
    check_val("s_wready_o", 64'(s_wready_o), 64'h0);
    check_val("s_arready_o", 64'(s_arready_o), 64'h0);
    check_val("s_bvalid_o", 64'(s_bvalid_o), 64'h0);
    check_val("s_rvalid_o", 64'(s_rvalid_o), 64'h0);
    $display("Reset state: %s", (errors == 0) ? "ok" : "mismatch");
    foreach (tbl[i]) begin
      test_err = 0;
      run_entry(tbl[i]);
      if (test_err != 0) begin
        bad_tests++;
      end
      $display("Test %2d %s addr %h: %s", i, tbl[i].is_wr ? "write" : "read ",
               tbl[i].addr, (test_err == 0) ? "ok" : "mismatch");
    end
    $display("%0d tests run, %0d with errors, %0d failed checks",
             tbl.size(), bad_tests, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: verilog/l2_mem.sv
// ##############################
// L2 memory top level
// AXI4-Lite slave over a tiled
// array of SRAM cuts
// ##############################

`timescale 1ns/1ps

module l2_mem (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  l2_mem_pkg::axi_addr_t s_awaddr_i,
  input  logic                  s_awvalid_i,
  output logic                  s_awready_o,
  input  l2_mem_pkg::axi_data_t s_wdata_i,
  input  l2_mem_pkg::axi_strb_t s_wstrb_i,
  input  logic                  s_wvalid_i,
  output logic                  s_wready_o,
  output l2_mem_pkg::axi_resp_t s_bresp_o,
  output logic                  s_bvalid_o,
  input  logic                  s_bready_i,
  input  l2_mem_pkg::axi_addr_t s_araddr_i,
  input  logic                  s_arvalid_i,
  output logic                  s_arready_o,
  output l2_mem_pkg::axi_data_t s_rdata_o,
  output l2_mem_pkg::axi_resp_t s_rresp_o,
  output logic                  s_rvalid_o,
  input  logic                  s_rready_i
);
  import l2_mem_pkg::*;

  axi_data_t row_rdata [N_ROWS];
  axi_data_t mem_rdata;

  // Single request bus broadcast to all rows
  l2_mem_req_if i_req_if ();

  axil_to_mem i_axil_to_mem (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .s_awaddr_i  (s_awaddr_i),
    .s_awvalid_i (s_awvalid_i),
    .s_awready_o (s_awready_o),
    .s_wdata_i   (s_wdata_i),
    .s_wstrb_i   (s_wstrb_i),
    .s_wvalid_i  (s_wvalid_i),
    .s_wready_o  (s_wready_o),
    .s_bresp_o   (s_bresp_o),
    .s_bvalid_o  (s_bvalid_o),
    .s_bready_i  (s_bready_i),
    .s_araddr_i  (s_araddr_i),
    .s_arvalid_i (s_arvalid_i),
    .s_arready_o (s_arready_o),
    .s_rdata_o   (s_rdata_o),
    .s_rresp_o   (s_rresp_o),
    .s_rvalid_o  (s_rvalid_o),
    .s_rready_i  (s_rready_i),
    .mem         (i_req_if.drv),
    .mem_rdata_i (mem_rdata)
  );

  for (genvar r = 0; r < N_ROWS; r++) begin : gen_row
    sram_cut #(
      .ROW_IDX (row_idx_t'(r))
    ) i_sram_cut (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .mem     (i_req_if.cut),
      .rdata_o (row_rdata[r])
    );
  end

  row_rdata_sel i_row_rdata_sel (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .mem         (i_req_if.mon),
    .row_rdata_i (row_rdata),
    .rdata_o     (mem_rdata)
  );

endmodule

// File: verilog/row_rdata_sel.sv
// ##############################
// Row read-data selector
// Picks the row read last cycle
// ##############################

`timescale 1ns/1ps

module row_rdata_sel (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  l2_mem_req_if.mon             mem,
  input  l2_mem_pkg::axi_data_t row_rdata_i [l2_mem_pkg::N_ROWS],
  output l2_mem_pkg::axi_data_t rdata_o
);
  import l2_mem_pkg::*;

  row_idx_t row_q;

  // Held until the next read and left alone by writes
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      row_q <= '0;
    end else if (mem.req && !mem.we) begin
      row_q <= mem.row;
    end
  end

  assign rdata_o = row_rdata_i[row_q];

endmodule

// File: verilog/sram_cut.sv
// ##############################
// One row of SRAM cuts
// Side-by-side 32-bit cuts with
// byte enables and row decode
// ##############################

`timescale 1ns/1ps

`include "l2_mem_consts.svh"

module sram_cut #(
  parameter l2_mem_pkg::row_idx_t ROW_IDX = '0
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  l2_mem_req_if.cut             mem,
  output l2_mem_pkg::axi_data_t rdata_o
);
  import l2_mem_pkg::*;

  logic row_hit;

  // Only this row's cuts see the broadcast request
  assign row_hit = mem.req && (mem.row == ROW_IDX);

  for (genvar c = 0; c < N_COLS; c++) begin : gen_col
    cut_data_t cells [`L2_CUT_WORDS];
    cut_data_t rdata_q;
    cut_data_t wdata_col;
    cut_strb_t strb_col;

    assign wdata_col = mem.wdata[c*`L2_CUT_DW +: `L2_CUT_DW];
    assign strb_col  = mem.strb[c*CUT_SB +: CUT_SB];

    always_ff @(posedge clk_i) begin
      if (row_hit && mem.we) begin
        for (int b = 0; b < CUT_SB; b++) begin
          if (strb_col[b]) begin
            cells[mem.word][b*8 +: 8] <= wdata_col[b*8 +: 8];
          end
        end
      end
    end

    // Read data appears one cycle after the request
    always_ff @(posedge clk_i, negedge rst_ni) begin
      if (!rst_ni) begin
        rdata_q <= '0;
      end else if (row_hit && !mem.we) begin
        rdata_q <= cells[mem.word];
      end
    end

    assign rdata_o[c*`L2_CUT_DW +: `L2_CUT_DW] = rdata_q;
  end

  a_req_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem.req |-> !$isunknown({mem.we, mem.row, mem.word}));

endmodule

// File: verilog/axil_to_mem.sv
// ##############################
// AXI4-Lite to memory adapter
// One transaction at a time, with
// range check and SLVERR
// ##############################

`timescale 1ns/1ps

`include "l2_mem_consts.svh"

module axil_to_mem (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Write address and data
  input  l2_mem_pkg::axi_addr_t s_awaddr_i,
  input  logic                  s_awvalid_i,
  output logic                  s_awready_o,
  input  l2_mem_pkg::axi_data_t s_wdata_i,
  input  l2_mem_pkg::axi_strb_t s_wstrb_i,
  input  logic                  s_wvalid_i,
  output logic                  s_wready_o,
  // Write response
  output l2_mem_pkg::axi_resp_t s_bresp_o,
  output logic                  s_bvalid_o,
  input  logic                  s_bready_i,
  // Read address
  input  l2_mem_pkg::axi_addr_t s_araddr_i,
  input  logic                  s_arvalid_i,
  output logic                  s_arready_o,
  // Read data
  output l2_mem_pkg::axi_data_t s_rdata_o,
  output l2_mem_pkg::axi_resp_t s_rresp_o,
  output logic                  s_rvalid_o,
  input  logic                  s_rready_i,
  // Memory side
  l2_mem_req_if.drv             mem,
  input  l2_mem_pkg::axi_data_t mem_rdata_i
);
  import l2_mem_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WRESP,
    ST_RWAIT,
    ST_RRESP
  } state_e;

  state_e    state_q;
  logic      wr_go;
  logic      rd_go;
  logic      wr_ok;
  logic      rd_ok;
  axi_addr_t req_addr;
  axi_resp_t bresp_q;
  axi_resp_t rresp_q;
  axi_data_t rdata_q;

  // Write needs both channels at once, and wins over a read
  assign wr_go = (state_q == ST_IDLE) && s_awvalid_i && s_wvalid_i;
  assign rd_go = (state_q == ST_IDLE) && s_arvalid_i && !wr_go;

  assign wr_ok = s_awaddr_i < axi_addr_t'(`L2_N_BYTES);
  assign rd_ok = s_araddr_i < axi_addr_t'(`L2_N_BYTES);

  assign s_awready_o = wr_go;
  assign s_wready_o  = wr_go;
  assign s_arready_o = rd_go;

  // Request goes out in the accepting cycle
  assign req_addr  = wr_go ? s_awaddr_i : s_araddr_i;
  assign mem.req   = (wr_go && wr_ok) || (rd_go && rd_ok);
  assign mem.we    = wr_go;
  assign mem.row   = req_addr[ROW_OFF +: ROW_W];
  assign mem.word  = req_addr[WORD_OFF +: WORD_W];
  assign mem.wdata = s_wdata_i;
  assign mem.strb  = s_wstrb_i;

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
      bresp_q <= RESP_OKAY;
      rresp_q <= RESP_OKAY;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (wr_go) begin
            state_q <= ST_WRESP;
            bresp_q <= wr_ok ? RESP_OKAY : RESP_SLVERR;
          end else if (rd_go) begin
            state_q <= ST_RWAIT;
            rresp_q <= rd_ok ? RESP_OKAY : RESP_SLVERR;
          end
        end
        ST_WRESP: begin
          if (s_bready_i) begin
            state_q <= ST_IDLE;
          end
        end
        // SRAM data is on mem_rdata_i in this cycle
        ST_RWAIT: begin
          state_q <= ST_RRESP;
        end
        ST_RRESP: begin
          if (s_rready_i) begin
            state_q <= ST_IDLE;
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // Error reads return zero
  always_ff @(posedge clk_i) begin
    if (state_q == ST_RWAIT) begin
      rdata_q <= (rresp_q == RESP_OKAY) ? mem_rdata_i : '0;
    end
  end

  assign s_bvalid_o = (state_q == ST_WRESP);
  assign s_bresp_o  = bresp_q;
  assign s_rvalid_o = (state_q == ST_RRESP);
  assign s_rresp_o  = rresp_q;
  assign s_rdata_o  = rdata_q;

  // Responses hold with stable payload until taken
  a_b_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    s_bvalid_o && !s_bready_i |=> s_bvalid_o && $stable(s_bresp_o));

  a_r_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    s_rvalid_o && !s_rready_i |=> s_rvalid_o && $stable({s_rresp_o, s_rdata_o}));

endmodule

// File: verilog/l2_mem_req_if.sv
// ##############################
// L2 memory request interface
// Adapter to rows and read mux
// ##############################

`timescale 1ns/1ps

interface l2_mem_req_if;
  import l2_mem_pkg::*;

  // Valid for the single cycle in which req is high
  logic      req;
  logic      we;
  row_idx_t  row;
  word_idx_t word;
  axi_data_t wdata;
  axi_strb_t strb;

  modport drv (
    output req, we, row, word, wdata, strb
  );

  // Seen by every row of cuts
  modport cut (
    input req, we, row, word, wdata, strb
  );

  // The read mux only tracks which row was read
  modport mon (
    input req, we, row
  );

endinterface

// File: verilog/l2_mem_pkg.sv
// ##############################
// L2 memory package
// Array geometry and bus types
// ##############################

`include "l2_mem_consts.svh"

package l2_mem_pkg;

  // Byte lanes of the bus and of one cut
  localparam int unsigned AXI_SB = `L2_AXI_DW / 8;
  localparam int unsigned CUT_SB = `L2_CUT_DW / 8;

  // Array geometry, cuts side by side form a row
  localparam int unsigned N_COLS    = `L2_AXI_DW / `L2_CUT_DW;
  localparam int unsigned ROW_BYTES = N_COLS * CUT_SB * `L2_CUT_WORDS;
  localparam int unsigned N_ROWS    = `L2_N_BYTES / ROW_BYTES;

  // Address split: byte offset, word index, row index
  localparam int unsigned WORD_OFF = $clog2(AXI_SB);
  localparam int unsigned WORD_W   = $clog2(`L2_CUT_WORDS);
  localparam int unsigned ROW_OFF  = WORD_OFF + WORD_W;
  localparam int unsigned ROW_W    = $clog2(N_ROWS);

  typedef logic [`L2_AXI_AW-1:0] axi_addr_t;
  typedef logic [`L2_AXI_DW-1:0] axi_data_t;
  typedef logic [AXI_SB-1:0]     axi_strb_t;
  typedef logic [WORD_W-1:0]     word_idx_t;
  typedef logic [ROW_W-1:0]      row_idx_t;
  typedef logic [`L2_CUT_DW-1:0] cut_data_t;
  typedef logic [CUT_SB-1:0]     cut_strb_t;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_t;

endpackage

// File: include/l2_mem_consts.svh
// ##############################
// L2 memory constants
// Bus, cut and memory sizes
// ##############################

`ifndef L2_MEM_CONSTS_SVH
`define L2_MEM_CONSTS_SVH

// AXI4-Lite bus widths in bits
`define L2_AXI_AW 32
`define L2_AXI_DW 64

// One SRAM cut
`define L2_CUT_DW 32
`define L2_CUT_WORDS 256

// Total memory size in bytes
`define L2_N_BYTES 8192

`endif
